// ==== include/pickup_defines.svh ====
`ifndef PICKUP_DEFINES_SVH
`define PICKUP_DEFINES_SVH

// visible screen area in pixels
`define SCREEN_WIDTH 640
`define SCREEN_HEIGHT 480

// position is kept in 1/64 pixel units
// must stay a power of two so the pixel value is a plain shift
`define FIXED_SCALE 64

// pickup is a square of this side in pixels
`define PICKUP_SIZE 32

// start row of a new pickup, one full square above the top edge
`define INITIAL_Y -32

// fall step per frame in fixed point units
// step = INITIAL_STEP + SPEED_STEP * speed
`define INITIAL_STEP 64
`define SPEED_STEP 32

// player box used for the take test
`define PLAYER_W 64
`define PLAYER_H 32

// frames to wait before a new pickup appears
// the low 4 random bits are added on top, so 4 to 19 frames
`define MIN_GAP 4

// start value of the spawner LFSR, any nonzero value works
`define LFSR_SEED 8'hA5

`endif

// ==== verilog/pickupPkg.sv ====
package pickupPkg;

	// signed screen coordinate, pickup may sit above the top edge
	typedef logic signed [10:0] coordT;

	// game speed set by the game logic
	typedef logic [2:0] speedT;

	// random byte from the spawner LFSR
	// used as a column in units of 2 pixels
	typedef logic [7:0] randT;

	// spawner FSM
	typedef enum logic [1:0] {
		sActiveWait, // pickup on screen, wait for it to leave
		sDelay, // count frames until the next spawn
		sDeploy // single cycle, pulses deploy
	} spawnStateT;

endpackage

// ==== verilog/pickupSpawner.sv ====
`timescale 1ns/1ns
`include "pickup_defines.svh"

module pickupSpawner (
	input logic clk,
	input logic resetN,
	input logic startOfFrame, // one-cycle strobe per frame
	input logic isActive, // pickup currently on screen
	output logic deploy, // one-cycle pulse, start a new pickup
	output pickupPkg::randT randomCol // column for the new pickup, valid with deploy
);

	localparam int cntW = 5; // holds MIN_GAP + 15

	pickupPkg::spawnStateT state; // FSM state
	pickupPkg::randT lfsr; // free running random source
	logic lfsrFeedback; // next bit shifted into the LFSR
	logic [cntW-1:0] framesLeft; // frames still to wait in sDelay
	logic [cntW-1:0] nextGap; // wait length picked when the pickup leaves

	// x^8 + x^6 + x^5 + x^4 + 1, maximal length
	assign lfsrFeedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lfsr <= `LFSR_SEED;
		end else begin
			lfsr <= {lfsr[6:0], lfsrFeedback}; // steps every clock
		end
	end

	// fixed minimum plus 0..15 random frames
	assign nextGap = cntW'(`MIN_GAP) + cntW'(lfsr[3:0]);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= pickupPkg::sDelay; // first pickup also waits
			framesLeft <= cntW'(`MIN_GAP) + cntW'(`LFSR_SEED & 8'h0F); // gap from the seed
		end else begin
			case (state)
				pickupPkg::sActiveWait: begin
					if (!isActive) begin // pickup left or was taken
						state <= pickupPkg::sDelay;
						framesLeft <= nextGap; // sample random gap now
					end
				end
				pickupPkg::sDelay: begin
					if (startOfFrame) begin // count frames only
						if (framesLeft == cntW'(1)) begin
							state <= pickupPkg::sDeploy; // last frame of the gap
						end
						framesLeft <= framesLeft - cntW'(1);
					end
				end
				pickupPkg::sDeploy: begin
					state <= pickupPkg::sActiveWait; // object goes active on this edge
				end
				default: begin
					state <= pickupPkg::sDelay; // recover from an illegal code
				end
			endcase
		end
	end

	assign deploy = (state == pickupPkg::sDeploy); // high for the single sDeploy cycle
	assign randomCol = lfsr; // object samples it with deploy

	// sDeploy always moves on, so a deploy never stretches
	deployOneCycle: assert property (
		@(posedge clk) disable iff (!resetN)
		deploy |=> !deploy
	) else $error("deploy held longer than one cycle");

	// a new pickup must not replace one still on screen
	noDeployWhileActive: assert property (
		@(posedge clk) disable iff (!resetN)
		deploy |-> !isActive
	) else $error("deploy while a pickup is active");

endmodule

// ==== verilog/pickupLogic.sv ====
`timescale 1ns/1ns
`include "pickup_defines.svh"

module pickupLogic (
	input logic clk,
	input logic resetN,
	input logic startOfFrame, // one-cycle strobe per frame
	input logic deploy, // start a new pickup
	input logic remove, // pickup was taken by the player
	input pickupPkg::randT randomCol, // column in units of 2 pixels
	input pickupPkg::speedT speed, // game speed, scales the fall step
	output pickupPkg::coordT pickupX, // top left corner in pixels
	output pickupPkg::coordT pickupY,
	output logic isActive // pickup is on screen
);

	localparam int fracBits = $clog2(`FIXED_SCALE); // shift from fixed point to pixels
	// parked X is the largest value, plus sign bit and headroom
	localparam int fixedW = $clog2(`SCREEN_WIDTH * `FIXED_SCALE) + 2;
	localparam int yLimit = (`SCREEN_HEIGHT - 1) * `FIXED_SCALE; // bottom row in fixed point
	localparam int xMax = 2 * ((1 << $bits(pickupPkg::randT)) - 1); // largest deploy column

	logic signed [fixedW-1:0] xFixed; // X in 1/64 pixel
	logic signed [fixedW-1:0] yFixed; // Y in 1/64 pixel
	logic signed [fixedW-1:0] step; // fall distance per frame

	// faster game, faster fall
	assign step = fixedW'(`INITIAL_STEP + `SPEED_STEP * int'(speed));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			xFixed <= fixedW'(`SCREEN_WIDTH * `FIXED_SCALE); // parked off screen
			yFixed <= fixedW'(`SCREEN_HEIGHT * `FIXED_SCALE);
			isActive <= 1'b0;
		end else if (remove) begin // taken, wins over everything
			xFixed <= fixedW'(`SCREEN_WIDTH * `FIXED_SCALE);
			yFixed <= fixedW'(`SCREEN_HEIGHT * `FIXED_SCALE);
			isActive <= 1'b0;
		end else if (deploy) begin
			xFixed <= fixedW'(int'(randomCol) * 2 * `FIXED_SCALE); // even column 0..510
			yFixed <= fixedW'(`INITIAL_Y * `FIXED_SCALE); // just above the screen
			isActive <= 1'b1;
		end else if (startOfFrame && isActive) begin // move once per frame
			if (yFixed > yLimit) begin
				isActive <= 1'b0; // fell past the bottom edge
			end else begin
				yFixed <= yFixed + step; // fall
			end
		end
	end

	// drop the fraction bits
	assign pickupX = pickupPkg::coordT'(xFixed >>> fracBits);
	assign pickupY = pickupPkg::coordT'(yFixed >>> fracBits);

	// deploy and remove both keep X consistent with isActive
	xInRange: assert property (
		@(posedge clk) disable iff (!resetN)
		isActive |-> (pickupX >= 0 && pickupX <= xMax)
	) else $error("pickupX %0d out of range while active", pickupX);

endmodule

// ==== verilog/pickupCollision.sv ====
`timescale 1ns/1ns
`include "pickup_defines.svh"

module pickupCollision (
	input logic clk,
	input logic resetN,
	input logic isActive, // pickup on screen
	input pickupPkg::coordT pickupX, // pickup top left corner
	input pickupPkg::coordT pickupY,
	input pickupPkg::coordT pixelX, // current scan position
	input pickupPkg::coordT pixelY,
	input pickupPkg::coordT playerX, // player top left corner
	input pickupPkg::coordT playerY,
	output logic drawRequest, // pixel belongs to the pickup, one cycle late
	output logic pickupTaken // one-cycle pulse on first overlap
);

	int pickupRight; // first column right of the pickup
	int pickupBottom; // first row below the pickup
	int playerRight; // first column right of the player
	int playerBottom; // first row below the player
	logic insidePickup; // scan pixel inside the square
	logic overlapNow; // boxes overlap this cycle
	logic overlapPrev; // overlap seen last cycle

	// int math so the player box can't wrap near the coordinate limit
	assign pickupRight = int'(pickupX) + `PICKUP_SIZE;
	assign pickupBottom = int'(pickupY) + `PICKUP_SIZE;
	assign playerRight = int'(playerX) + `PLAYER_W;
	assign playerBottom = int'(playerY) + `PLAYER_H;

	// half open square, left and top edges included
	assign insidePickup = isActive
		&& (pixelX >= pickupX) && (int'(pixelX) < pickupRight)
		&& (pixelY >= pickupY) && (int'(pixelY) < pickupBottom);

	// rectangles overlap when each starts before the other ends
	assign overlapNow = isActive
		&& (int'(pickupX) < playerRight) && (int'(playerX) < pickupRight)
		&& (int'(pickupY) < playerBottom) && (int'(playerY) < pickupBottom);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drawRequest <= 1'b0;
			overlapPrev <= 1'b0;
			pickupTaken <= 1'b0;
		end else begin
			drawRequest <= insidePickup; // registered for the pixel pipeline
			overlapPrev <= overlapNow;
			pickupTaken <= overlapNow && !overlapPrev; // rising edge only
		end
	end

	// taken pulse clears isActive through remove, so it can't repeat
	takenSinglePulse: assert property (
		@(posedge clk) disable iff (!resetN)
		pickupTaken |=> !pickupTaken
	) else $error("pickupTaken high on two consecutive cycles");

endmodule

// ==== verilog/pickupTop.sv ====
`timescale 1ns/1ns

module pickupTop (
	input logic clk,
	input logic resetN,
	input logic startOfFrame, // one-cycle strobe per frame
	input pickupPkg::speedT speed, // game speed
	input pickupPkg::coordT pixelX, // scan position from the VGA timing
	input pickupPkg::coordT pixelY,
	input pickupPkg::coordT playerX, // player top left corner
	input pickupPkg::coordT playerY,
	output pickupPkg::coordT pickupX, // pickup top left corner
	output pickupPkg::coordT pickupY,
	output logic isActive, // pickup on screen
	output logic drawRequest, // draw pickup at this pixel
	output logic pickupTaken // player grabbed the pickup
);

	logic deploy; // spawner to object
	pickupPkg::randT randomCol; // column for a new pickup

	// decides when and where the next pickup appears
	pickupSpawner spawner (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.isActive(isActive),
		.deploy(deploy),
		.randomCol(randomCol)
	);

	// position state of the falling pickup
	pickupLogic pickup (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.deploy(deploy),
		.remove(pickupTaken), // take removes the pickup
		.randomCol(randomCol),
		.speed(speed),
		.pickupX(pickupX),
		.pickupY(pickupY),
		.isActive(isActive)
	);

	// draw request and player overlap
	pickupCollision collision (
		.clk(clk),
		.resetN(resetN),
		.isActive(isActive),
		.pickupX(pickupX),
		.pickupY(pickupY),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.playerX(playerX),
		.playerY(playerY),
		.drawRequest(drawRequest),
		.pickupTaken(pickupTaken)
	);

endmodule

// ==== verif/clockGen.sv ====
`timescale 1ns/1ns

module clockGen (
	output logic clk,
	output logic resetN
);

	localparam int halfPeriod = 20; // 40 ns clock
	localparam int resetCycles = 5;

	initial begin
		clk = 1'b0;
		forever begin
			#halfPeriod clk = ~clk;
		end
	end

	initial begin
		resetN = 1'b1; // idle before the reset edge
		#1;
		resetN = 1'b0; // falling edge starts the async reset
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		resetN = 1'b1; // release away from the sampling edge
	end

endmodule

// ==== verif/pickupTb.sv ====
`timescale 1ns/1ns

module pickupTb;

	localparam int frameLen = 20; // cycles per frame
	localparam int runFrames = 400;
	localparam int clkPeriod = 40;

	logic clk;
	logic resetN;
	logic startOfFrame;
	pickupPkg::speedT speed;
	pickupPkg::coordT pixelX;
	pickupPkg::coordT pixelY;
	pickupPkg::coordT playerX;
	pickupPkg::coordT playerY;
	pickupPkg::coordT pickupX;
	pickupPkg::coordT pickupY;
	logic isActive;
	logic drawRequest;
	logic pickupTaken;

	integer seed = 32'hb3fe;
	int checkErrors = 0; // assertion failures
	int otherErrors = 0; // timeouts and missing coverage
	int frameCnt = 0;
	logic fastOnly = 1'b1; // fast falls while waiting for an exit
	logic prevActive; // isActive one cycle back
	logic prevTaken;
	logic gapArmed; // counting a respawn gap after an exit
	int gapCount; // strobes seen since the exit
	int exitsSeen;
	int takesSeen;
	logic expInside; // tb model of a pixel inside the square
	logic expOverlap; // tb model of the player box over the pickup
	int stepLo; // smallest pixel step for this speed
	int stepHi;

	clockGen clockGenInst (
		.clk(clk),
		.resetN(resetN)
	);

	pickupTop DUT (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.speed(speed),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.playerX(playerX),
		.playerY(playerY),
		.pickupX(pickupX),
		.pickupY(pickupY),
		.isActive(isActive),
		.drawRequest(drawRequest),
		.pickupTaken(pickupTaken)
	);

	// fall step is (64 + 32*speed)/64 px and the fraction may round either way
	assign stepLo = (64 + 32 * int'(speed)) / 64;
	assign stepHi = (64 + 32 * int'(speed) + 63) / 64;

	assign expInside = isActive
		&& int'(pixelX) >= int'(pickupX) && int'(pixelX) < int'(pickupX) + 32
		&& int'(pixelY) >= int'(pickupY) && int'(pixelY) < int'(pickupY) + 32;

	assign expOverlap = isActive
		&& int'(pickupX) < int'(playerX) + 64 && int'(playerX) < int'(pickupX) + 32
		&& int'(pickupY) < int'(playerY) + 32 && int'(playerY) < int'(pickupY) + 32;

	// frame strobe, speed and scan pixel all change on the falling edge
	always @(negedge clk) begin
		startOfFrame <= (frameCnt == frameLen - 1);
		frameCnt <= (frameCnt == frameLen - 1) ? 0 : frameCnt + 1;
		if (frameCnt == 0) begin
			speed <= fastOnly ? (3'd4 | 3'($random(seed) & 3)) : 3'($random(seed));
		end
		pixelX <= pickupX + 11'(($random(seed) & 63) - 16); // scatter around the square
		pixelY <= pickupY + 11'(($random(seed) & 63) - 16);
	end

	// exit and gap bookkeeping for the respawn check
	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			prevActive <= 1'b0;
			prevTaken <= 1'b0;
			gapArmed <= 1'b0;
			gapCount <= 0;
			exitsSeen <= 0;
			takesSeen <= 0;
		end else begin
			prevActive <= isActive;
			prevTaken <= pickupTaken;
			if (pickupTaken) begin
				takesSeen <= takesSeen + 1;
			end
			if (prevActive && !isActive && !prevTaken) begin // fell out the bottom
				gapArmed <= 1'b1;
				gapCount <= 0;
				exitsSeen <= exitsSeen + 1;
			end else if (!isActive && startOfFrame) begin
				gapCount <= gapCount + 1;
			end else if (isActive && prevActive) begin
				gapArmed <= 1'b0;
			end
		end
	end

	resetState: assert property (@(posedge clk)
		(!resetN || $rose(resetN)) |-> (!isActive && !drawRequest && !pickupTaken
			&& pickupX == 640 && pickupY == 480)
	) else begin
		checkErrors++;
		$display("Fail %0t reset isActive,drawRequest,pickupTaken expected 000 got %b%b%b",
			$time, isActive, drawRequest, pickupTaken);
		$display("Fail %0t reset pickupX,pickupY expected 640,480 got %0d,%0d",
			$time, pickupX, pickupY);
	end

	spawnPosition: assert property (@(posedge clk) disable iff (!resetN)
		$rose(isActive) |-> (pickupY == -32 && !pickupX[0] && pickupX >= 0 && pickupX <= 510)
	) else begin
		checkErrors++;
		$display("Fail %0t pickupY expected -32 got %0d", $time, pickupY);
		$display("Fail %0t pickupX expected even 0..510 got %0d", $time, pickupX);
	end

	fallStep: assert property (@(posedge clk) disable iff (!resetN)
		(startOfFrame && isActive && !pickupTaken && pickupY < 479) |=>
			(int'(pickupY) - int'($past(pickupY)) >= $past(stepLo)
			&& int'(pickupY) - int'($past(pickupY)) <= $past(stepHi))
	) else begin
		checkErrors++;
		$display("Fail %0t pickupY expected %0d + %0d..%0d got %0d",
			$time, $past(pickupY), $past(stepLo), $past(stepHi), pickupY);
	end

	// row 479 may still hold one last fall, and that one lands below the screen
	bottomExit: assert property (@(posedge clk) disable iff (!resetN)
		(startOfFrame && isActive && !pickupTaken && pickupY >= 479) |=>
			(!isActive || ($past(pickupY) == 479 && pickupY >= 480))
	) else begin
		checkErrors++;
		$display("Fail %0t isActive expected 0 got %b after bottom edge at row %0d",
			$time, isActive, $past(pickupY));
	end

	respawnGap: assert property (@(posedge clk) disable iff (!resetN)
		($rose(isActive) && gapArmed) |-> (gapCount >= 4 && gapCount <= 19)
	) else begin
		checkErrors++;
		$display("Fail %0t respawn gap expected 4..19 strobes got %0d", $time, gapCount);
	end

	drawCheck: assert property (@(posedge clk) disable iff (!resetN)
		1'b1 |=> (drawRequest == $past(expInside))
	) else begin
		checkErrors++;
		$display("Fail %0t drawRequest expected %b got %b",
			$time, $past(expInside), drawRequest);
	end

	takeCause: assert property (@(posedge clk) disable iff (!resetN)
		pickupTaken |-> $past(expOverlap)
	) else begin
		checkErrors++;
		$display("Fail %0t pickupTaken expected 0 got 1 without overlap", $time);
	end

	takeEffect: assert property (@(posedge clk) disable iff (!resetN)
		pickupTaken |=> (!pickupTaken && !isActive && pickupX == 640 && pickupY == 480)
	) else begin
		checkErrors++;
		$display("Fail %0t after take pickupTaken,isActive expected 0,0 got %b,%b",
			$time, pickupTaken, isActive);
		$display("Fail %0t after take pickupX,pickupY expected 640,480 got %0d,%0d",
			$time, pickupX, pickupY);
	end

	task automatic parkPlayer();
		@(negedge clk);
		playerX = 11'sd900; // far corner where no overlap is possible
		playerY = 11'sd900;
	endtask

	task automatic takeOne();
		int waited;
		waited = 0;
		while (!(isActive && pickupY >= 0) && waited < 60 * frameLen) begin
			@(posedge clk);
			waited++;
		end
		@(negedge clk);
		playerX = pickupX - 11'($random(seed) & 31); // box covers the square
		playerY = pickupY - 11'($random(seed) & 15);
		waited = 0;
		while (!pickupTaken && waited < 100) begin
			@(posedge clk);
			waited++;
		end
		if (!pickupTaken) begin
			otherErrors++;
			$display("player was placed on the pickup but no take happened at %0t", $time);
		end
		parkPlayer();
	endtask

	initial begin
		startOfFrame = 1'b0;
		speed = 3'd4;
		pixelX = 11'sd0;
		pixelY = 11'sd0;
		playerX = 11'sd900;
		playerY = 11'sd900;
		@(negedge resetN);
		@(posedge resetN);
		// let pickups fall through untouched until one leaves the screen
		while (exitsSeen == 0) begin
			@(posedge clk);
		end
		fastOnly = 1'b0;
		repeat (2) takeOne();
		repeat (3) @(posedge clk);
		if (takesSeen < 2) begin
			otherErrors++;
			$display("expected two takes but saw %0d", takesSeen);
		end
		$display("errors: %0d check failures, %0d other failures", checkErrors, otherErrors);
		if (checkErrors == 0 && otherErrors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(runFrames * frameLen * clkPeriod);
		otherErrors++;
		$display("watchdog expired before the tests finished");
		$display("errors: %0d check failures, %0d other failures", checkErrors, otherErrors);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+include
verilog/pickupPkg.sv
verilog/pickupSpawner.sv
verilog/pickupLogic.sv
verilog/pickupCollision.sv
verilog/pickupTop.sv
verif/clockGen.sv
verif/pickupTb.sv

// ==== Makefile ====
# Verilator build for the pickup subsystem testbench

VERILATOR ?= verilator
TOP ?= pickupTb
OBJ_DIR ?= obj_dir
FILELIST ?= sources.f
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= RESULT: PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
